// File: inval_pkg.sv
package inval_pkg;

  // ----------------------------------------------------------
  // Bus and cache geometry
  // ----------------------------------------------------------

  // AXI write path widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned STRB_W = DATA_W / 8;

  // L1 line layout: offset, then set index, then tag
  localparam int unsigned LINE_BYTES = 16;
  localparam int unsigned LINE_OFF_W = $clog2(LINE_BYTES);
  localparam int unsigned L1_SETS    = 16;
  localparam int unsigned SET_W      = $clog2(L1_SETS);
  localparam int unsigned TAG_W      = ADDR_W - SET_W - LINE_OFF_W;

  // Outstanding write addresses waiting for invalidation
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // Config bus and counter
  localparam int unsigned CNT_W     = 16;
  localparam int unsigned WB_ADR_W  = 4;
  localparam int unsigned WB_DATA_W = 32;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [WB_DATA_W-1:0] wb_data_t;

  // ----------------------------------------------------------
  // AXI write channels
  // ----------------------------------------------------------

  typedef struct packed {
    logic [ID_W-1:0] id;
    addr_t           addr;
    logic [7:0]      len;
    logic [2:0]      size;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } axi_b_t;

  // Master to slave direction
  typedef struct packed {
    axi_aw_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
  } axi_req_t;

  // Slave to master direction
  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    axi_b_t b;
    logic   b_valid;
  } axi_resp_t;

  // Line invalidation request toward the L1
  typedef struct packed {
    addr_t addr;
    logic  valid;
  } inval_req_t;

  // ----------------------------------------------------------
  // Wishbone config bus
  // ----------------------------------------------------------

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    wb_data_t            dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  typedef enum logic {
    FILT_IDLE,
    FILT_INVAL
  } filter_state_e;

  typedef enum logic [WB_ADR_W-1:0] {
    REG_CTRL    = 4'h0,
    REG_INV_CNT = 4'h4
  } cfg_reg_e;

endpackage

// File: aw_fifo.sv
module aw_fifo (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push_i,
  input  inval_pkg::axi_aw_t data_i,
  input  logic               pop_i,
  output inval_pkg::axi_aw_t data_o,
  output logic               full_o,
  output logic               empty_o
);

  // Storage, no reset needed on the payload
  inval_pkg::axi_aw_t mem_q [inval_pkg::FIFO_DEPTH];

  logic [inval_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
  logic [inval_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
  logic [inval_pkg::FIFO_PTR_W:0]   cnt_q;
  logic                             stored_empty;
  logic                             bypass;
  logic                             do_push;
  logic                             do_pop;

  assign stored_empty = (cnt_q == '0);
  assign full_o       = (cnt_q == (inval_pkg::FIFO_PTR_W + 1)'(inval_pkg::FIFO_DEPTH));
  // Fall through: an incoming beat makes the FIFO look non-empty at once
  assign empty_o      = stored_empty & ~push_i;
  assign data_o       = stored_empty ? data_i : mem_q[rd_ptr_q];

  // Push and pop on an empty FIFO skip the storage entirely
  assign bypass  = stored_empty & push_i & pop_i;
  assign do_push = push_i & ~full_o & ~bypass;
  assign do_pop  = pop_i & ~stored_empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Count only moves when exactly one side acts
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: axi_inval_filter.sv
module axi_inval_filter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  enable_i,
  input  inval_pkg::axi_req_t   slv_req_i,
  output inval_pkg::axi_resp_t  slv_resp_o,
  output inval_pkg::axi_req_t   mst_req_o,
  input  inval_pkg::axi_resp_t  mst_resp_i,
  output inval_pkg::inval_req_t inval_o,
  input  logic                  inval_ready_i
);

  logic                     fifo_full;
  logic                     fifo_empty;
  logic                     fifo_push;
  logic                     fifo_pop;
  inval_pkg::axi_aw_t       fifo_head;
  inval_pkg::addr_t         offset_d;
  inval_pkg::addr_t         offset_q;
  inval_pkg::addr_t         next_offset;
  inval_pkg::addr_t         burst_bytes;
  logic                     last_line;
  logic                     inval_fire;
  inval_pkg::filter_state_e state_d;
  inval_pkg::filter_state_e state_q;

  // ----------------------------------------------------------
  // Write channel pass-through
  // ----------------------------------------------------------

  always_comb begin
    mst_req_o  = slv_req_i;
    slv_resp_o = mst_resp_i;
    // Hold off new addresses while the queue is full
    if (fifo_full && enable_i) begin
      slv_resp_o.aw_ready = 1'b0;
    end
  end

  // Queue every accepted AW while snooping is on
  assign fifo_push = slv_req_i.aw_valid & slv_resp_o.aw_ready & enable_i;

  aw_fifo i_aw_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (fifo_push),
    .data_i  (slv_req_i.aw),
    .pop_i   (fifo_pop),
    .data_o  (fifo_head),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  // ----------------------------------------------------------
  // Line stepping
  // ----------------------------------------------------------

  // Request for the line at the current offset of the head burst
  assign inval_o.valid = ~fifo_empty;
  assign inval_o.addr  = fifo_head.addr + offset_q;
  assign inval_fire    = inval_o.valid & inval_ready_i;

  // Total burst bytes, (len + 1) << size
  assign burst_bytes = (inval_pkg::addr_t'(fifo_head.len) + 1'b1) << fifo_head.size;
  assign next_offset = offset_q + inval_pkg::addr_t'(inval_pkg::LINE_BYTES);
  // Current line is the final one of this burst
  assign last_line   = (next_offset >= burst_bytes);

  always_comb begin
    state_d  = state_q;
    offset_d = offset_q;
    fifo_pop = 1'b0;
    case (state_q)
      inval_pkg::FILT_IDLE: begin
        // First line goes out at offset zero
        if (inval_fire) begin
          if (last_line) begin
            fifo_pop = 1'b1;
          end else begin
            state_d  = inval_pkg::FILT_INVAL;
            offset_d = next_offset;
          end
        end
      end
      inval_pkg::FILT_INVAL: begin
        // Step one line per accepted request
        if (inval_fire) begin
          if (last_line) begin
            state_d  = inval_pkg::FILT_IDLE;
            offset_d = '0;
            fifo_pop = 1'b1;
          end else begin
            offset_d = next_offset;
          end
        end
      end
      default: begin
        state_d  = inval_pkg::FILT_IDLE;
        offset_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= inval_pkg::FILT_IDLE;
      offset_q <= '0;
    end else begin
      state_q  <= state_d;
      offset_q <= offset_d;
    end
  end

endmodule

// File: l1_tag_store.sv
module l1_tag_store (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fill_valid_i,
  input  logic [inval_pkg::ADDR_W-1:0] fill_addr_i,
  input  inval_pkg::inval_req_t       inval_i,
  output logic                        inval_ready_o,
  input  logic [inval_pkg::ADDR_W-1:0] lookup_addr_i,
  output logic                        lookup_hit_o
);

  // ----------------------------------------------------------
  // Tag and valid arrays
  // ----------------------------------------------------------

  logic [inval_pkg::L1_SETS-1:0]                       valid_q;
  logic [inval_pkg::L1_SETS-1:0][inval_pkg::TAG_W-1:0] tag_q;

  // Address split per port
  logic [inval_pkg::SET_W-1:0] fill_set;
  logic [inval_pkg::TAG_W-1:0] fill_tag;
  logic [inval_pkg::SET_W-1:0] inv_set;
  logic [inval_pkg::TAG_W-1:0] inv_tag;
  logic [inval_pkg::SET_W-1:0] lk_set;
  logic [inval_pkg::TAG_W-1:0] lk_tag;
  logic                        inv_accept;
  logic                        inv_match;

  assign fill_set = fill_addr_i[inval_pkg::LINE_OFF_W +: inval_pkg::SET_W];
  assign fill_tag = fill_addr_i[inval_pkg::ADDR_W-1 -: inval_pkg::TAG_W];
  assign inv_set  = inval_i.addr[inval_pkg::LINE_OFF_W +: inval_pkg::SET_W];
  assign inv_tag  = inval_i.addr[inval_pkg::ADDR_W-1 -: inval_pkg::TAG_W];
  assign lk_set   = lookup_addr_i[inval_pkg::LINE_OFF_W +: inval_pkg::SET_W];
  assign lk_tag   = lookup_addr_i[inval_pkg::ADDR_W-1 -: inval_pkg::TAG_W];

  // ----------------------------------------------------------
  // Write port arbitration
  // ----------------------------------------------------------

  // Fill owns the single write port when active
  assign inval_ready_o = ~fill_valid_i;
  assign inv_accept    = inval_i.valid & inval_ready_o;
  // Only a line holding the same tag is dropped
  assign inv_match     = (tag_q[inv_set] == inv_tag);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      tag_q   <= '0;
    end else if (fill_valid_i) begin
      valid_q[fill_set] <= 1'b1;
      tag_q[fill_set]   <= fill_tag;
    end else if (inv_accept && inv_match) begin
      valid_q[inv_set] <= 1'b0;
    end
  end

  // Combinational lookup on the stored state
  assign lookup_hit_o = valid_q[lk_set] & (tag_q[lk_set] == lk_tag);

endmodule

// File: inval_cfg_regs.sv
module inval_cfg_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  inval_pkg::wb_req_t wb_req_i,
  output inval_pkg::wb_rsp_t wb_rsp_o,
  input  logic               inval_fire_i,
  output logic               enable_o
);

  logic                        ack_q;
  inval_pkg::wb_data_t         rdata_d;
  inval_pkg::wb_data_t         rdata_q;
  logic                        enable_q;
  logic [inval_pkg::CNT_W-1:0] cnt_q;
  logic                        wb_access;
  logic                        wr_ctrl;
  logic                        wr_cnt;
  logic                        cnt_full;

  // ----------------------------------------------------------
  // Bus decode
  // ----------------------------------------------------------

  // New access seen, ack goes out on the next cycle
  assign wb_access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign wr_ctrl   = wb_access & wb_req_i.we & (wb_req_i.adr == inval_pkg::REG_CTRL);
  assign wr_cnt    = wb_access & wb_req_i.we & (wb_req_i.adr == inval_pkg::REG_INV_CNT);
  assign cnt_full  = &cnt_q;

  // Read mux, unmapped offsets return zero
  always_comb begin
    case (wb_req_i.adr)
      inval_pkg::REG_CTRL:    rdata_d = inval_pkg::wb_data_t'(enable_q);
      inval_pkg::REG_INV_CNT: rdata_d = inval_pkg::wb_data_t'(cnt_q);
      default:                rdata_d = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      enable_q <= 1'b1;
      cnt_q    <= '0;
    end else begin
      ack_q <= wb_access;
      if (wr_ctrl) begin
        enable_q <= wb_req_i.dat[0];
      end
      // Clear beats a same-edge increment
      if (wr_cnt) begin
        cnt_q <= '0;
      end else if (inval_fire_i && !cnt_full) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Read data captured with the access, shown with ack
  always_ff @(posedge clk_i) begin
    if (wb_access) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;
  assign enable_o     = enable_q;

endmodule

// File: inval_subsys_top.sv
module inval_subsys_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  inval_pkg::axi_req_t          slv_req_i,
  output inval_pkg::axi_resp_t         slv_resp_o,
  output inval_pkg::axi_req_t          mst_req_o,
  input  inval_pkg::axi_resp_t         mst_resp_i,
  input  inval_pkg::wb_req_t           wb_req_i,
  output inval_pkg::wb_rsp_t           wb_rsp_o,
  input  logic                         fill_valid_i,
  input  logic [inval_pkg::ADDR_W-1:0] fill_addr_i,
  input  logic [inval_pkg::ADDR_W-1:0] lookup_addr_i,
  output logic                         lookup_hit_o
);

  // Filter to L1 request and its handshake
  inval_pkg::inval_req_t inval;
  logic                  inval_ready;
  logic                  inval_fire;
  logic                  enable;

  // Counted once per accepted line request
  assign inval_fire = inval.valid & inval_ready;

  axi_inval_filter i_filter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (enable),
    .slv_req_i     (slv_req_i),
    .slv_resp_o    (slv_resp_o),
    .mst_req_o     (mst_req_o),
    .mst_resp_i    (mst_resp_i),
    .inval_o       (inval),
    .inval_ready_i (inval_ready)
  );

  l1_tag_store i_tag_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fill_valid_i  (fill_valid_i),
    .fill_addr_i   (fill_addr_i),
    .inval_i       (inval),
    .inval_ready_o (inval_ready),
    .lookup_addr_i (lookup_addr_i),
    .lookup_hit_o  (lookup_hit_o)
  );

  // Config block, enable line back into the filter
  inval_cfg_regs i_cfg_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_req_i     (wb_req_i),
    .wb_rsp_o     (wb_rsp_o),
    .inval_fire_i (inval_fire),
    .enable_o     (enable)
  );

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // Free running clock, period 10
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset low for two rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: inval_subsys_assert.sv
module inval_subsys_assert (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  enable_i,
  input inval_pkg::axi_resp_t  slv_resp_i,
  input inval_pkg::inval_req_t inval_i,
  input logic                  inval_ready_i,
  input logic                  fifo_push_i,
  input logic                  fifo_pop_i
);

  // Failure tally, summed into the final verdict
  int unsigned fail_cnt = 0;

  // Shadow occupancy, kept from the push and pop strobes alone
  int unsigned occ_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= 0;
    end else begin
      occ_q <= occ_q + (fifo_push_i ? 1 : 0) - (fifo_pop_i ? 1 : 0);
    end
  end

  // Stalled request keeps valid and its line address
  stall_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    inval_i.valid && !inval_ready_i |=> inval_i.valid && $stable(inval_i.addr))
    else begin
      $error("invalidation request changed while stalled");
      fail_cnt++;
    end

  // Pop only with a beat queued or arriving in the same cycle
  no_empty_pop_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_pop_i |-> (occ_q != 0) || fifo_push_i)
    else begin
      $error("AW FIFO popped while empty");
      fail_cnt++;
    end

  // Full queue closes the AW channel
  full_gate_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (occ_q == inval_pkg::FIFO_DEPTH) && enable_i |-> !slv_resp_i.aw_ready)
    else begin
      $error("aw_ready high while the AW FIFO is full");
      fail_cnt++;
    end

endmodule

bind axi_inval_filter inval_subsys_assert i_assert (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .enable_i      (enable_i),
  .slv_resp_i    (slv_resp_o),
  .inval_i       (inval_o),
  .inval_ready_i (inval_ready_i),
  .fifo_push_i   (fifo_push),
  .fifo_pop_i    (fifo_pop)
);

// File: inval_subsys_tb.sv
module inval_subsys_tb;

  // Five tests take a few hundred cycles together, four times that as limit
  localparam int unsigned TIMEOUT_CYCLES = 2000;

  logic                         clk;
  logic                         rst_n;
  inval_pkg::axi_req_t          slv_req;
  inval_pkg::axi_resp_t         slv_resp;
  inval_pkg::axi_req_t          mst_req;
  inval_pkg::axi_resp_t         mst_resp;
  inval_pkg::wb_req_t           wb_req;
  inval_pkg::wb_rsp_t           wb_rsp;
  logic                         fill_valid;
  logic [inval_pkg::ADDR_W-1:0] fill_addr;
  logic [inval_pkg::ADDR_W-1:0] lookup_addr;
  logic                         lookup_hit;

  int unsigned errors;
  int unsigned checks;
  int unsigned tests;
  int unsigned cycles;
  int unsigned exp_cnt;
  logic [7:0]  lfsr_q;

  // Memory model state
  logic [inval_pkg::ID_W-1:0] aw_ids [$];
  inval_pkg::axi_b_t          b_pend [$];
  logic                       b_taken = 1'b0;

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  inval_subsys_top inval_subsys_top_i (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .slv_req_i     (slv_req),
    .slv_resp_o    (slv_resp),
    .mst_req_o     (mst_req),
    .mst_resp_i    (mst_resp),
    .wb_req_i      (wb_req),
    .wb_rsp_o      (wb_rsp),
    .fill_valid_i  (fill_valid),
    .fill_addr_i   (fill_addr),
    .lookup_addr_i (lookup_addr),
    .lookup_hit_o  (lookup_hit)
  );

  // ----------------------------------------------------------
  // Memory model and run limit
  // ----------------------------------------------------------

  // AW counts once the master side has seen it accepted
  always @(posedge clk) begin
    if (rst_n) begin
      if (mst_req.aw_valid && mst_resp.aw_ready && slv_resp.aw_ready) begin
        aw_ids.push_back(mst_req.aw.id);
      end
      if (mst_req.w_valid && mst_resp.w_ready && mst_req.w.last) begin
        b_pend.push_back('{id: aw_ids.pop_front(), resp: 2'b00});
      end
      if (mst_resp.b_valid && mst_req.b_ready) begin
        b_taken = 1'b1;
      end
    end
  end

  // B responses presented on the falling edge
  always @(negedge clk) begin
    if (b_taken) begin
      mst_resp.b_valid = 1'b0;
      b_taken = 1'b0;
    end
    if (!mst_resp.b_valid && b_pend.size() > 0) begin
      mst_resp.b       = b_pend.pop_front();
      mst_resp.b_valid = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  // Fibonacci LFSR, taps 8 6 5 4, one step per bit
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Lines covered by a burst, at least one
  function automatic int unsigned lines_of(input inval_pkg::axi_aw_t aw);
    int unsigned bytes;
    int unsigned off;
    int unsigned n;
    bytes = (int'(aw.len) + 1) << aw.size;
    n = 0;
    off = 0;
    do begin
      n++;
      off += inval_pkg::LINE_BYTES;
    end while (off < bytes);
    return n;
  endfunction

  function automatic inval_pkg::axi_aw_t make_aw(input logic [31:0] addr,
                                                 input logic [7:0] len);
    inval_pkg::axi_aw_t aw;
    logic [31:0]        bits;
    bits    = take_bits(inval_pkg::ID_W);
    aw.id   = bits[inval_pkg::ID_W-1:0];
    aw.addr = addr;
    aw.len  = len;
    aw.size = 3'd2;
    return aw;
  endfunction

  task automatic cmp_aw(input string name, input inval_pkg::axi_aw_t exp,
                        input inval_pkg::axi_aw_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_w(input string name, input inval_pkg::axi_w_t exp,
                       input inval_pkg::axi_w_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_b(input string name, input inval_pkg::axi_b_t exp,
                       input inval_pkg::axi_b_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_hit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic cmp_word(input string name, input inval_pkg::wb_data_t exp,
                          input inval_pkg::wb_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h actual %h", name, exp, act);
    end
  endtask

  // One Wishbone classic cycle, data sampled with ack
  task automatic wb_cycle(input logic we, input inval_pkg::cfg_reg_e adr,
                          input inval_pkg::wb_data_t wdat, output inval_pkg::wb_data_t rdat);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    do begin
      @(posedge clk);
    end while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    @(negedge clk);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic reg_write(input inval_pkg::cfg_reg_e adr, input inval_pkg::wb_data_t wdat);
    inval_pkg::wb_data_t unused;
    wb_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic reg_check(input string name, input inval_pkg::cfg_reg_e adr,
                           input inval_pkg::wb_data_t exp);
    inval_pkg::wb_data_t rdat;
    wb_cycle(1'b0, adr, '0, rdat);
    cmp_word(name, exp, rdat);
  endtask

  task automatic fill_line(input logic [31:0] addr);
    @(negedge clk);
    fill_valid = 1'b1;
    fill_addr  = addr;
    @(negedge clk);
    fill_valid = 1'b0;
  endtask

  task automatic check_line(input string name, input logic [31:0] addr, input logic exp);
    @(negedge clk);
    lookup_addr = addr;
    @(posedge clk);
    cmp_hit(name, exp, lookup_hit);
  endtask

  // W beats, each checked on the memory side
  task automatic w_send(input string name, input logic [7:0] len);
    for (int i = 0; i <= len; i++) begin
      @(negedge clk);
      slv_req.w.data  = take_bits(32);
      slv_req.w.strb  = '1;
      slv_req.w.last  = (i == len);
      slv_req.w_valid = 1'b1;
      do begin
        @(posedge clk);
      end while (!slv_resp.w_ready);
      cmp_w({name, " w"}, slv_req.w, mst_req.w);
      cmp_hit({name, " w valid"}, 1'b1, mst_req.w_valid);
    end
    @(negedge clk);
    slv_req.w_valid = 1'b0;
  endtask

  task automatic b_check(input string name, input logic [inval_pkg::ID_W-1:0] id);
    do begin
      @(posedge clk);
    end while (!slv_resp.b_valid);
    cmp_b({name, " b"}, '{id: id, resp: 2'b00}, slv_resp.b);
    cmp_hit({name, " b ready"}, 1'b1, mst_req.b_ready);
  endtask

  // Full write: AW, then W beats, then B
  task automatic do_write(input string name, input inval_pkg::axi_aw_t aw);
    @(negedge clk);
    slv_req.aw       = aw;
    slv_req.aw_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (!slv_resp.aw_ready);
    cmp_aw({name, " aw"}, aw, mst_req.aw);
    cmp_hit({name, " aw valid"}, 1'b1, mst_req.aw_valid);
    @(negedge clk);
    slv_req.aw_valid = 1'b0;
    w_send(name, aw.len);
    b_check(name, aw.id);
  endtask

  // Invalidation queue drained
  task automatic wait_idle();
    do begin
      @(posedge clk);
    end while (inval_subsys_top_i.inval.valid);
  endtask

  task automatic end_test(input string name, input int unsigned err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d error(s)", name, errors - err_before);
    end
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------

  task automatic test_pass_through();
    int unsigned e0;
    inval_pkg::axi_aw_t aw;
    e0 = errors;
    aw = make_aw(32'h0000_1000, 8'd3);
    do_write("pass", aw);
    wait_idle();
    exp_cnt += lines_of(aw);
    reg_check("pass count", inval_pkg::REG_INV_CNT, exp_cnt);
    end_test("pass_through", e0);
  endtask

  task automatic test_single_line();
    int unsigned e0;
    logic [3:0]  s0;
    logic [31:0] addr [4];
    e0 = errors;
    reg_write(inval_pkg::REG_INV_CNT, '0);
    exp_cnt = 0;
    s0 = 4'(take_bits(4));
    // Four distinct sets, random tags
    for (int k = 0; k < 4; k++) begin
      addr[k] = {16'h0001, 8'(take_bits(8)), 4'(s0 + 4'(4 * k)), 4'h0};
      fill_line(addr[k]);
    end
    do_write("single", make_aw(addr[0], 8'd0));
    wait_idle();
    exp_cnt += 1;
    check_line("single target", addr[0], 1'b0);
    for (int k = 1; k < 4; k++) begin
      check_line("single other", addr[k], 1'b1);
    end
    reg_check("single count", inval_pkg::REG_INV_CNT, exp_cnt);
    end_test("single_line", e0);
  endtask

  task automatic test_multi_line();
    int unsigned e0;
    inval_pkg::axi_aw_t aw;
    e0 = errors;
    for (int k = 0; k < 5; k++) begin
      fill_line(32'h0002_0000 + 32'(k * inval_pkg::LINE_BYTES));
    end
    aw = make_aw(32'h0002_0000, 8'd15);
    do_write("burst", aw);
    wait_idle();
    exp_cnt += lines_of(aw);
    for (int k = 0; k < 5; k++) begin
      check_line("burst line", 32'h0002_0000 + 32'(k * inval_pkg::LINE_BYTES), k == 4);
    end
    reg_check("burst count", inval_pkg::REG_INV_CNT, exp_cnt);
    end_test("multi_line", e0);
  endtask

  task automatic test_disable();
    int unsigned e0;
    e0 = errors;
    reg_write(inval_pkg::REG_CTRL, '0);
    fill_line(32'h0003_0080);
    do_write("disabled", make_aw(32'h0003_0080, 8'd0));
    wait_idle();
    check_line("disabled line", 32'h0003_0080, 1'b1);
    reg_check("disabled count", inval_pkg::REG_INV_CNT, exp_cnt);
    reg_write(inval_pkg::REG_INV_CNT, '0);
    exp_cnt = 0;
    reg_check("cleared count", inval_pkg::REG_INV_CNT, '0);
    reg_write(inval_pkg::REG_CTRL, 32'd1);
    reg_check("enable back", inval_pkg::REG_CTRL, 32'd1);
    end_test("disable", e0);
  endtask

  task automatic test_back_pressure();
    int unsigned e0;
    inval_pkg::axi_aw_t aw;
    e0 = errors;
    for (int k = 0; k <= inval_pkg::FIFO_DEPTH; k++) begin
      fill_line(32'h0004_0000 + 32'(k * inval_pkg::LINE_BYTES));
    end
    // Steady refill of set 15 keeps the write port busy
    @(negedge clk);
    fill_valid = 1'b1;
    fill_addr  = 32'h0005_00F0;
    for (int k = 0; k < inval_pkg::FIFO_DEPTH; k++) begin
      do_write("queued", make_aw(32'h0004_0000 + 32'(k * inval_pkg::LINE_BYTES), 8'd0));
    end
    aw = make_aw(32'h0004_0000 + 32'(inval_pkg::FIFO_DEPTH * inval_pkg::LINE_BYTES), 8'd0);
    @(negedge clk);
    slv_req.aw       = aw;
    slv_req.aw_valid = 1'b1;
    repeat (3) begin
      @(posedge clk);
      cmp_hit("back_pressure aw_ready", 1'b0, slv_resp.aw_ready);
    end
    @(negedge clk);
    fill_valid = 1'b0;
    do begin
      @(posedge clk);
    end while (!slv_resp.aw_ready);
    cmp_aw("extra aw", aw, mst_req.aw);
    @(negedge clk);
    slv_req.aw_valid = 1'b0;
    w_send("extra", 8'd0);
    b_check("extra", aw.id);
    wait_idle();
    exp_cnt += inval_pkg::FIFO_DEPTH + 1;
    for (int k = 0; k <= inval_pkg::FIFO_DEPTH; k++) begin
      check_line("stalled line", 32'h0004_0000 + 32'(k * inval_pkg::LINE_BYTES), 1'b0);
    end
    reg_check("stalled count", inval_pkg::REG_INV_CNT, exp_cnt);
    end_test("back_pressure", e0);
  endtask

  initial begin
    slv_req          = '0;
    slv_req.b_ready  = 1'b1;
    mst_resp         = '0;
    mst_resp.aw_ready = 1'b1;
    mst_resp.w_ready = 1'b1;
    wb_req           = '0;
    fill_valid       = 1'b0;
    fill_addr        = '0;
    lookup_addr      = '0;
    errors           = 0;
    checks           = 0;
    tests            = 0;
    cycles           = 0;
    exp_cnt          = 0;
    lfsr_q           = 8'd86;
    @(posedge rst_n);
    test_pass_through();
    test_single_line();
    test_multi_line();
    test_disable();
    test_back_pressure();
    $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, inval_subsys_top_i.i_filter.i_assert.fail_cnt);
    if (errors == 0 && inval_subsys_top_i.i_filter.i_assert.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
inval_pkg.sv
aw_fifo.sv
axi_inval_filter.sv
l1_tag_store.sv
inval_cfg_regs.sv
inval_subsys_top.sv
tb_clk_gen.sv
inval_subsys_assert.sv
inval_subsys_tb.sv

// File: Bender.yml
package:
  name: inval_subsys

sources:
  - inval_pkg.sv
  - aw_fifo.sv
  - axi_inval_filter.sv
  - l1_tag_store.sv
  - inval_cfg_regs.sv
  - inval_subsys_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - inval_subsys_assert.sv
      - inval_subsys_tb.sv
